/* logic/rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

	// data path width
	localparam int XLEN = 32;

	// major opcodes handled by this slice
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	// alu operations carried from decode to execute
	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_OR    = 4'd3,
		ALU_XOR   = 4'd4,
		ALU_SLT   = 4'd5,
		ALU_SLTU  = 4'd6,
		ALU_SLL   = 4'd7,
		ALU_SRL   = 4'd8,
		ALU_SRA   = 4'd9,
		// operand b straight through, used by lui
		ALU_PASSB = 4'd10
	} alu_op_e;

	// branch compare kinds, index is {funct3[2], funct3[0]}
	typedef enum logic [1:0] {
		BR_EQ = 2'd0,
		BR_NE = 2'd1,
		BR_LT = 2'd2,
		BR_GE = 2'd3
	} br_type_e;

	// register-register layout
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_view_t;

	// store / branch layout, immediate split around the register fields
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} sb_view_t;

	// one instruction word, two ways of reading it
	typedef union packed {
		r_view_t  r;
		sb_view_t sb;
	} inst_word_u;

endpackage

`default_nettype wire

/* logic/rv_id_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_id_decode #(
	parameter int PC_WIDTH = 12
) (
	input  wire                               in_valid,
	input  rv_pipe_pkg::inst_word_u           in_inst,
	input  wire [PC_WIDTH-1:0]                in_pc,
	input  wire [rv_pipe_pkg::XLEN-1:0]       in_opa,
	input  wire [rv_pipe_pkg::XLEN-1:0]       in_opb,

	output logic                              id_valid,
	output logic [PC_WIDTH-1:0]               id_pc,
	output logic [rv_pipe_pkg::XLEN-1:0]      id_opa,
	output logic [rv_pipe_pkg::XLEN-1:0]      id_opb,
	output logic [rv_pipe_pkg::XLEN-1:0]      id_imm,
	output logic [4:0]                        id_rd,
	output rv_pipe_pkg::alu_op_e              id_alu_op,
	output logic                              id_sel_imm,
	output logic                              id_wr_en,
	output logic                              id_is_branch,
	output rv_pipe_pkg::br_type_e             id_br_type
);

	logic                              is_op;
	logic [rv_pipe_pkg::XLEN-1:0]      imm_i;
	logic [rv_pipe_pkg::XLEN-1:0]      imm_u;
	logic [rv_pipe_pkg::XLEN-1:0]      imm_b;
	rv_pipe_pkg::alu_op_e              funct_op;
	logic                              writes;
	logic                              branch;

	assign is_op = (in_inst.r.opcode == rv_pipe_pkg::OPC_OP);

	// immediates, funct7 and rs2 together form imm[11:0] of an I-type
	assign imm_i = {{20{in_inst.r.funct7[6]}}, in_inst.r.funct7, in_inst.r.rs2};
	assign imm_u = {in_inst.r.funct7, in_inst.r.rs2, in_inst.r.rs1, in_inst.r.funct3, 12'b0};
	// B-type bit shuffle out of the split store layout
	assign imm_b = {{19{in_inst.sb.imm_hi[6]}}, in_inst.sb.imm_hi[6], in_inst.sb.imm_lo[0],
		in_inst.sb.imm_hi[5:0], in_inst.sb.imm_lo[4:1], 1'b0};

	// funct3 / funct7 to alu op, sub only exists for register-register
	always_comb begin
		case (in_inst.r.funct3)
			3'b000: begin
				if (is_op && in_inst.r.funct7[5])
					funct_op = rv_pipe_pkg::ALU_SUB;
				else
					funct_op = rv_pipe_pkg::ALU_ADD;
			end
			3'b001: funct_op = rv_pipe_pkg::ALU_SLL;
			3'b010: funct_op = rv_pipe_pkg::ALU_SLT;
			3'b011: funct_op = rv_pipe_pkg::ALU_SLTU;
			3'b100: funct_op = rv_pipe_pkg::ALU_XOR;
			3'b101: begin
				if (in_inst.r.funct7[5])
					funct_op = rv_pipe_pkg::ALU_SRA;
				else
					funct_op = rv_pipe_pkg::ALU_SRL;
			end
			3'b110: funct_op = rv_pipe_pkg::ALU_OR;
			default: funct_op = rv_pipe_pkg::ALU_AND;
		endcase
	end

	always_comb begin
		id_imm = '0;
		id_alu_op = rv_pipe_pkg::ALU_ADD;
		id_sel_imm = 1'b0;
		writes = 1'b0;
		branch = 1'b0;
		case (in_inst.r.opcode)
			rv_pipe_pkg::OPC_OP: begin
				id_alu_op = funct_op;
				writes = 1'b1;
			end
			rv_pipe_pkg::OPC_OP_IMM: begin
				id_imm = imm_i;
				id_alu_op = funct_op;
				id_sel_imm = 1'b1;
				writes = 1'b1;
			end
			rv_pipe_pkg::OPC_LUI: begin
				id_imm = imm_u;
				id_alu_op = rv_pipe_pkg::ALU_PASSB;
				id_sel_imm = 1'b1;
				writes = 1'b1;
			end
			rv_pipe_pkg::OPC_BRANCH: begin
				id_imm = imm_b;
				// beq, bne, blt, bge have funct3[1] clear
				branch = !in_inst.r.funct3[1];
			end
			default: ;
		endcase
	end

	always_comb begin
		case ({in_inst.r.funct3[2], in_inst.r.funct3[0]})
			2'b00: id_br_type = rv_pipe_pkg::BR_EQ;
			2'b01: id_br_type = rv_pipe_pkg::BR_NE;
			2'b10: id_br_type = rv_pipe_pkg::BR_LT;
			default: id_br_type = rv_pipe_pkg::BR_GE;
		endcase
	end

	// bubbles carry no side effects
	assign id_wr_en = in_valid && writes && (in_inst.r.rd != 5'd0);
	assign id_is_branch = in_valid && branch;

	assign id_valid = in_valid;
	assign id_pc = in_pc;
	assign id_opa = in_opa;
	assign id_opb = in_opb;
	assign id_rd = in_inst.r.rd;

endmodule

`default_nettype wire

/* logic/pipereg_id_exe.sv */
`timescale 1ns/10ps
`default_nettype none

module pipereg_id_exe #(
	parameter int PC_WIDTH = 12
) (
	input  wire                               clk,
	input  wire                               reset,
	input  wire                               en,
	input  wire                               stall,
	input  wire                               flush,

	input  wire                               id_valid,
	input  wire [PC_WIDTH-1:0]                id_pc,
	input  wire [rv_pipe_pkg::XLEN-1:0]       id_opa,
	input  wire [rv_pipe_pkg::XLEN-1:0]       id_opb,
	input  wire [rv_pipe_pkg::XLEN-1:0]       id_imm,
	input  wire [4:0]                         id_rd,
	input  rv_pipe_pkg::alu_op_e              id_alu_op,
	input  wire                               id_sel_imm,
	input  wire                               id_wr_en,
	input  wire                               id_is_branch,
	input  rv_pipe_pkg::br_type_e             id_br_type,

	output logic                              exe_valid,
	output logic [PC_WIDTH-1:0]               exe_pc,
	output logic [rv_pipe_pkg::XLEN-1:0]      exe_opa,
	output logic [rv_pipe_pkg::XLEN-1:0]      exe_opb,
	output logic [rv_pipe_pkg::XLEN-1:0]      exe_imm,
	output logic [4:0]                        exe_rd,
	output rv_pipe_pkg::alu_op_e              exe_alu_op,
	output logic                              exe_sel_imm,
	output logic                              exe_wr_en,
	output logic                              exe_is_branch,
	output rv_pipe_pkg::br_type_e             exe_br_type
);

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			// flush turns the slot into a bubble
			exe_valid <= 1'b0;
			exe_pc <= '0;
			exe_opa <= '0;
			exe_opb <= '0;
			exe_imm <= '0;
			exe_rd <= 5'd0;
			exe_alu_op <= rv_pipe_pkg::ALU_ADD;
			exe_sel_imm <= 1'b0;
			exe_wr_en <= 1'b0;
			exe_is_branch <= 1'b0;
			exe_br_type <= rv_pipe_pkg::BR_EQ;
		end else if (en && !stall) begin
			exe_valid <= id_valid;
			exe_pc <= id_pc;
			exe_opa <= id_opa;
			exe_opb <= id_opb;
			exe_imm <= id_imm;
			exe_rd <= id_rd;
			exe_alu_op <= id_alu_op;
			exe_sel_imm <= id_sel_imm;
			exe_wr_en <= id_wr_en;
			exe_is_branch <= id_is_branch;
			exe_br_type <= id_br_type;
		end
	end

endmodule

`default_nettype wire

/* logic/rv_exe_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_exe_stage #(
	parameter int PC_WIDTH = 12
) (
	input  wire                               clk,
	input  wire                               reset,
	input  wire                               en,
	input  wire                               stall,

	input  wire                               exe_valid,
	input  wire [PC_WIDTH-1:0]                exe_pc,
	input  wire [rv_pipe_pkg::XLEN-1:0]       exe_opa,
	input  wire [rv_pipe_pkg::XLEN-1:0]       exe_opb,
	input  wire [rv_pipe_pkg::XLEN-1:0]       exe_imm,
	input  wire [4:0]                         exe_rd,
	input  rv_pipe_pkg::alu_op_e              exe_alu_op,
	input  wire                               exe_sel_imm,
	input  wire                               exe_wr_en,
	input  wire                               exe_is_branch,
	input  rv_pipe_pkg::br_type_e             exe_br_type,

	output logic                              out_valid,
	output logic [PC_WIDTH-1:0]               out_pc,
	output logic [4:0]                        out_rd,
	output logic                              out_wr_en,
	output logic [rv_pipe_pkg::XLEN-1:0]      out_result,
	output logic                              out_is_branch,
	output logic                              out_taken,
	output logic [PC_WIDTH-1:0]               out_target
);

	logic [rv_pipe_pkg::XLEN-1:0]      alu_b;
	logic [rv_pipe_pkg::XLEN-1:0]      alu_val;
	logic [4:0]                        shamt;
	logic                              cmp;
	logic [PC_WIDTH-1:0]               target;

	assign alu_b = exe_sel_imm ? exe_imm : exe_opb;
	// only the low five bits count as shift amount
	assign shamt = alu_b[4:0];

	always_comb begin
		case (exe_alu_op)
			rv_pipe_pkg::ALU_ADD:   alu_val = exe_opa + alu_b;
			rv_pipe_pkg::ALU_SUB:   alu_val = exe_opa - alu_b;
			rv_pipe_pkg::ALU_AND:   alu_val = exe_opa & alu_b;
			rv_pipe_pkg::ALU_OR:    alu_val = exe_opa | alu_b;
			rv_pipe_pkg::ALU_XOR:   alu_val = exe_opa ^ alu_b;
			rv_pipe_pkg::ALU_SLT:
				alu_val = {{(rv_pipe_pkg::XLEN-1){1'b0}}, $signed(exe_opa) < $signed(alu_b)};
			rv_pipe_pkg::ALU_SLTU:
				alu_val = {{(rv_pipe_pkg::XLEN-1){1'b0}}, exe_opa < alu_b};
			rv_pipe_pkg::ALU_SLL:   alu_val = exe_opa << shamt;
			rv_pipe_pkg::ALU_SRL:   alu_val = exe_opa >> shamt;
			rv_pipe_pkg::ALU_SRA:   alu_val = $signed(exe_opa) >>> shamt;
			rv_pipe_pkg::ALU_PASSB: alu_val = alu_b;
			default:                alu_val = '0;
		endcase
	end

	// branch compare always on the two register operands
	always_comb begin
		case (exe_br_type)
			rv_pipe_pkg::BR_EQ: cmp = (exe_opa == exe_opb);
			rv_pipe_pkg::BR_NE: cmp = (exe_opa != exe_opb);
			rv_pipe_pkg::BR_LT: cmp = ($signed(exe_opa) < $signed(exe_opb));
			default:            cmp = ($signed(exe_opa) >= $signed(exe_opb));
		endcase
	end

	// wraps inside the pc space
	assign target = exe_pc + exe_imm[PC_WIDTH-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			out_wr_en <= 1'b0;
			out_is_branch <= 1'b0;
			out_taken <= 1'b0;
		end else if (en && !stall) begin
			out_valid <= exe_valid;
			out_wr_en <= exe_wr_en;
			out_is_branch <= exe_is_branch;
			out_taken <= exe_is_branch && cmp;
		end else begin
			// stalled edge gives no result
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (en && !stall) begin
			out_pc <= exe_pc;
			out_rd <= exe_rd;
			out_result <= exe_wr_en ? alu_val : '0;
			out_target <= target;
		end
	end

endmodule

`default_nettype wire

/* logic/rv_id_exe_slice.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_id_exe_slice #(
	parameter int PC_WIDTH = 12
) (
	input  wire                               clk,
	input  wire                               reset,

	input  wire                               in_valid,
	input  rv_pipe_pkg::inst_word_u           in_inst,
	input  wire [PC_WIDTH-1:0]                in_pc,
	input  wire [rv_pipe_pkg::XLEN-1:0]       in_opa,
	input  wire [rv_pipe_pkg::XLEN-1:0]       in_opb,
	input  wire                               en,
	input  wire                               stall,
	input  wire                               flush,

	output logic                              out_valid,
	output logic [PC_WIDTH-1:0]               out_pc,
	output logic [4:0]                        out_rd,
	output logic                              out_wr_en,
	output logic [rv_pipe_pkg::XLEN-1:0]      out_result,
	output logic                              out_is_branch,
	output logic                              out_taken,
	output logic [PC_WIDTH-1:0]               out_target
);

	// decode side of the stage register
	logic                              id_valid;
	logic [PC_WIDTH-1:0]               id_pc;
	logic [rv_pipe_pkg::XLEN-1:0]      id_opa;
	logic [rv_pipe_pkg::XLEN-1:0]      id_opb;
	logic [rv_pipe_pkg::XLEN-1:0]      id_imm;
	logic [4:0]                        id_rd;
	rv_pipe_pkg::alu_op_e              id_alu_op;
	logic                              id_sel_imm;
	logic                              id_wr_en;
	logic                              id_is_branch;
	rv_pipe_pkg::br_type_e             id_br_type;

	// execute side
	logic                              exe_valid;
	logic [PC_WIDTH-1:0]               exe_pc;
	logic [rv_pipe_pkg::XLEN-1:0]      exe_opa;
	logic [rv_pipe_pkg::XLEN-1:0]      exe_opb;
	logic [rv_pipe_pkg::XLEN-1:0]      exe_imm;
	logic [4:0]                        exe_rd;
	rv_pipe_pkg::alu_op_e              exe_alu_op;
	logic                              exe_sel_imm;
	logic                              exe_wr_en;
	logic                              exe_is_branch;
	rv_pipe_pkg::br_type_e             exe_br_type;

	rv_id_decode #(.PC_WIDTH(PC_WIDTH)) u_decode (
		.in_valid     (in_valid),
		.in_inst      (in_inst),
		.in_pc        (in_pc),
		.in_opa       (in_opa),
		.in_opb       (in_opb),
		.id_valid     (id_valid),
		.id_pc        (id_pc),
		.id_opa       (id_opa),
		.id_opb       (id_opb),
		.id_imm       (id_imm),
		.id_rd        (id_rd),
		.id_alu_op    (id_alu_op),
		.id_sel_imm   (id_sel_imm),
		.id_wr_en     (id_wr_en),
		.id_is_branch (id_is_branch),
		.id_br_type   (id_br_type)
	);

	pipereg_id_exe #(.PC_WIDTH(PC_WIDTH)) u_pipereg (
		.clk           (clk),
		.reset         (reset),
		.en            (en),
		.stall         (stall),
		.flush         (flush),
		.id_valid      (id_valid),
		.id_pc         (id_pc),
		.id_opa        (id_opa),
		.id_opb        (id_opb),
		.id_imm        (id_imm),
		.id_rd         (id_rd),
		.id_alu_op     (id_alu_op),
		.id_sel_imm    (id_sel_imm),
		.id_wr_en      (id_wr_en),
		.id_is_branch  (id_is_branch),
		.id_br_type    (id_br_type),
		.exe_valid     (exe_valid),
		.exe_pc        (exe_pc),
		.exe_opa       (exe_opa),
		.exe_opb       (exe_opb),
		.exe_imm       (exe_imm),
		.exe_rd        (exe_rd),
		.exe_alu_op    (exe_alu_op),
		.exe_sel_imm   (exe_sel_imm),
		.exe_wr_en     (exe_wr_en),
		.exe_is_branch (exe_is_branch),
		.exe_br_type   (exe_br_type)
	);

	rv_exe_stage #(.PC_WIDTH(PC_WIDTH)) u_exe (
		.clk           (clk),
		.reset         (reset),
		.en            (en),
		.stall         (stall),
		.exe_valid     (exe_valid),
		.exe_pc        (exe_pc),
		.exe_opa       (exe_opa),
		.exe_opb       (exe_opb),
		.exe_imm       (exe_imm),
		.exe_rd        (exe_rd),
		.exe_alu_op    (exe_alu_op),
		.exe_sel_imm   (exe_sel_imm),
		.exe_wr_en     (exe_wr_en),
		.exe_is_branch (exe_is_branch),
		.exe_br_type   (exe_br_type),
		.out_valid     (out_valid),
		.out_pc        (out_pc),
		.out_rd        (out_rd),
		.out_wr_en     (out_wr_en),
		.out_result    (out_result),
		.out_is_branch (out_is_branch),
		.out_taken     (out_taken),
		.out_target    (out_target)
	);

endmodule

`default_nettype wire

/* tb/rv_id_exe_slice_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_id_exe_slice_assert #(
	parameter int FIELD_W = 8
) (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 stall,
	input  wire                 flush,
	input  wire                 exe_valid,
	input  wire                 exe_wr_en,
	input  wire                 exe_is_branch,
	// all exe_ fields side by side
	input  wire [FIELD_W-1:0]   exe_fields
);

	// read by the testbench top
	int unsigned fail_count = 0;

	clear_gives_bubble: assert property (@(posedge clk) (reset || flush) |=> !exe_valid)
	else begin
		fail_count++;
		$error("exe_valid high after a reset or flush edge");
	end

	stall_holds_fields: assert property (@(posedge clk)
		(stall && !flush && !reset) |=> $stable(exe_fields))
	else begin
		fail_count++;
		$error("exe_ fields changed on a stalled edge");
	end

	// a branch never writes a register
	write_or_branch: assert property (@(posedge clk) disable iff (reset)
		!(exe_wr_en && exe_is_branch))
	else begin
		fail_count++;
		$error("exe_wr_en and exe_is_branch both high");
	end

endmodule

`default_nettype wire

/* tb/tb_rv_id_exe_slice.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_id_exe_slice;

	localparam int PC_WIDTH = 12;
	localparam int XLEN = rv_pipe_pkg::XLEN;
	// about 3300 edges over all phases, random mix dominates
	localparam int TEST_CYCLES = 4000;

	typedef struct packed {
		logic [PC_WIDTH-1:0] pc;
		logic [4:0]          rd;
		logic                wr_en;
		logic [XLEN-1:0]     result;
		logic                is_branch;
		logic                taken;
		logic [PC_WIDTH-1:0] target;
	} exp_t;

	logic                    clk = 1'b0;
	logic                    reset;
	logic                    in_valid;
	rv_pipe_pkg::inst_word_u in_inst;
	logic [PC_WIDTH-1:0]     in_pc;
	logic [XLEN-1:0]         in_opa;
	logic [XLEN-1:0]         in_opb;
	logic                    en;
	logic                    stall;
	logic                    flush;
	logic                    out_valid;
	logic [PC_WIDTH-1:0]     out_pc;
	logic [4:0]              out_rd;
	logic                    out_wr_en;
	logic [XLEN-1:0]         out_result;
	logic                    out_is_branch;
	logic                    out_taken;
	logic [PC_WIDTH-1:0]     out_target;

	exp_t exp_q[$];
	int   accept_q[$];
	int   cycle = 0;
	bit   check_latency = 1'b0;
	bit   edge_blocked = 1'b1;

	rv_id_exe_slice #(.PC_WIDTH(PC_WIDTH)) u_rv_id_exe_slice (.*);

	bind pipereg_id_exe rv_id_exe_slice_assert #(
		.FIELD_W(PC_WIDTH + 3 * rv_pipe_pkg::XLEN + 15)
	) u_assert (
		.clk           (clk),
		.reset         (reset),
		.stall         (stall),
		.flush         (flush),
		.exe_valid     (exe_valid),
		.exe_wr_en     (exe_wr_en),
		.exe_is_branch (exe_is_branch),
		.exe_fields    ({exe_valid, exe_pc, exe_opa, exe_opb, exe_imm, exe_rd, exe_alu_op,
			exe_sel_imm, exe_wr_en, exe_is_branch, exe_br_type})
	);

	always #2 clk = ~clk;

	// edge count and whether the last edge could produce a result
	always @(posedge clk) begin
		cycle <= cycle + 1;
		edge_blocked <= reset || !en || stall;
	end

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
		if (act !== exp) begin
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_pc(string name, logic [PC_WIDTH-1:0] exp, logic [PC_WIDTH-1:0] act);
		if (act !== exp) begin
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_reg(string name, logic [4:0] exp, logic [4:0] act);
		if (act !== exp) begin
			$display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	// expected outputs straight from the RV32I encoding rules
	function automatic exp_t ref_exec(rv_pipe_pkg::inst_word_u w, logic [PC_WIDTH-1:0] pc,
			logic [XLEN-1:0] a, logic [XLEN-1:0] b);
		exp_t            e;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] opnd;
		logic [XLEN-1:0] val;
		logic [4:0]      sh;
		logic            is_reg;
		e = '0;
		val = '0;
		e.pc = pc;
		e.rd = w.r.rd;
		is_reg = (w.r.opcode == rv_pipe_pkg::OPC_OP);
		imm = XLEN'($signed(w[31:20]));
		opnd = is_reg ? b : imm;
		sh = opnd[4:0];
		case (w.r.funct3)
			3'd0: val = (is_reg && w.r.funct7[5]) ? a - opnd : a + opnd;
			3'd1: val = a << sh;
			3'd2: val[0] = $signed(a) < $signed(opnd);
			3'd3: val[0] = a < opnd;
			3'd4: val = a ^ opnd;
			3'd5: begin
				if (w.r.funct7[5])
					val = $signed(a) >>> sh;
				else
					val = a >> sh;
			end
			3'd6: val = a | opnd;
			default: val = a & opnd;
		endcase
		case (w.r.opcode)
			rv_pipe_pkg::OPC_OP, rv_pipe_pkg::OPC_OP_IMM: begin
				e.wr_en = (w.r.rd != 5'd0);
				e.result = e.wr_en ? val : '0;
			end
			rv_pipe_pkg::OPC_LUI: begin
				e.wr_en = (w.r.rd != 5'd0);
				e.result = e.wr_en ? {w[31:12], 12'h000} : '0;
			end
			rv_pipe_pkg::OPC_BRANCH: begin
				// funct3 010, 011, 110, 111 pass as no-ops
				if (!w.r.funct3[1]) begin
					imm = XLEN'($signed({w.sb.imm_hi[6], w.sb.imm_lo[0], w.sb.imm_hi[5:0],
						w.sb.imm_lo[4:1], 1'b0}));
					e.is_branch = 1'b1;
					case (w.r.funct3)
						3'd0: e.taken = (a == b);
						3'd1: e.taken = (a != b);
						3'd4: e.taken = ($signed(a) < $signed(b));
						default: e.taken = ($signed(a) >= $signed(b));
					endcase
					e.target = pc + imm[PC_WIDTH-1:0];
				end
			end
			default: ;
		endcase
		return e;
	endfunction

	function automatic rv_pipe_pkg::inst_word_u make_inst(logic [6:0] hi, logic [4:0] rs2,
			logic [2:0] f3, logic [4:0] lo, logic [6:0] opc);
		rv_pipe_pkg::inst_word_u w;
		w.r.funct7 = hi;
		w.r.rs2 = rs2;
		w.r.rs1 = 5'd1;
		w.r.funct3 = f3;
		w.r.rd = lo;
		w.r.opcode = opc;
		return w;
	endfunction

	function automatic rv_pipe_pkg::inst_word_u make_branch(logic [2:0] f3, logic [12:0] off);
		return make_inst({off[12], off[10:5]}, 5'd2, f3, {off[4:1], off[11]},
			rv_pipe_pkg::OPC_BRANCH);
	endfunction

	function automatic rv_pipe_pkg::inst_word_u random_inst();
		rv_pipe_pkg::inst_word_u w;
		w = $urandom();
		case ($urandom_range(0, 4))
			0: w.r.opcode = rv_pipe_pkg::OPC_OP;
			1: w.r.opcode = rv_pipe_pkg::OPC_OP_IMM;
			2: w.r.opcode = rv_pipe_pkg::OPC_LUI;
			3: w.r.opcode = rv_pipe_pkg::OPC_BRANCH;
			// random opcode, nearly always unsupported
			default: ;
		endcase
		return w;
	endfunction

	// present one cycle of input, record it if it will be accepted
	task automatic drive(bit v, rv_pipe_pkg::inst_word_u w, logic [XLEN-1:0] a,
			logic [XLEN-1:0] b, bit st, bit fl);
		logic [PC_WIDTH-1:0] pc;
		pc = PC_WIDTH'($urandom());
		in_valid = v;
		in_inst = w;
		in_pc = pc;
		in_opa = a;
		in_opb = b;
		stall = st;
		flush = fl;
		if (v && en && !st && !fl && !reset) begin
			exp_q.push_back(ref_exec(w, pc, a, b));
			accept_q.push_back(cycle + 1);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 20) begin
			drive(1'b0, '0, '0, '0, 1'b0, 1'b0);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("pipeline did not drain, %0d results never came out", exp_q.size());
			abort_run();
		end
	endtask

	always @(negedge clk) begin : compare_outputs
		exp_t e;
		int   acc;
		if (u_rv_id_exe_slice.u_pipereg.u_assert.fail_count != 0) begin
			$display("an assertion on the ID/EXE register failed before %0t ns", $time);
			abort_run();
		end else if (edge_blocked && out_valid !== 1'b0) begin
			$display("out_valid high after a reset, stalled or disabled edge at %0t ns", $time);
			abort_run();
		end else if (out_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("a result came out at %0t ns with no instruction outstanding", $time);
				abort_run();
			end else begin
				e = exp_q.pop_front();
				acc = accept_q.pop_front();
				if (check_latency && cycle - acc != 1) begin
					$display("result at %0t ns arrived %0d edges after acceptance, not 1",
						$time, cycle - acc);
					abort_run();
				end
				check_pc("out_pc", e.pc, out_pc);
				check_reg("out_rd", e.rd, out_rd);
				check_bit("out_wr_en", e.wr_en, out_wr_en);
				check_word("out_result", e.result, out_result);
				check_bit("out_is_branch", e.is_branch, out_is_branch);
				check_bit("out_taken", e.taken, out_taken);
				if (e.is_branch)
					check_pc("out_target", e.target, out_target);
			end
		end
	end

	initial begin : watchdog
		#(TEST_CYCLES * 4 * 2);
		$display("run did not finish within %0d cycles", TEST_CYCLES * 2);
		$display("FAIL: see errors above");
		$fatal(1, "timeout");
	end

	initial begin : stimulus
		logic [XLEN-1:0] pa [4];
		logic [XLEN-1:0] pb [4];
		logic [11:0]     imms [4];
		logic [11:0]     imm12;
		int              issued;
		bit              v;
		bit              st;
		bit              fl;
		void'($urandom(32'h2f086232));
		reset = 1'b1;
		in_valid = 1'b0;
		in_inst = '0;
		in_pc = '0;
		in_opa = '0;
		in_opb = '0;
		en = 1'b1;
		stall = 1'b0;
		flush = 1'b0;
		pa = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_fff0, 32'h1234_5678};
		pb = '{32'h0000_0001, 32'hffff_ffff, 32'd35, 32'h8765_4321};
		imms = '{12'h800, 12'h7ff, 12'h023, 12'hfff};
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		// every alu op, register and immediate forms
		check_latency = 1'b1;
		for (int p = 0; p < 4; p++) begin
			for (int f = 0; f < 10; f++)
				drive(1'b1, make_inst((f >= 8) ? 7'h20 : 7'h00, 5'd2,
					(f == 9) ? 3'd5 : 3'(f % 8), 5'(f + 1), rv_pipe_pkg::OPC_OP),
					pa[p], pb[p], 1'b0, 1'b0);
			for (int f = 0; f < 9; f++) begin
				imm12 = (f == 8) ? {7'h20, imms[p][4:0]} : imms[p];
				drive(1'b1, make_inst(imm12[11:5], imm12[4:0], (f == 8) ? 3'd5 : 3'(f),
					5'(f + 11), rv_pipe_pkg::OPC_OP_IMM), pa[p], pb[p], 1'b0, 1'b0);
			end
		end
		drain();

		// branches on equal, less and greater pairs, then lui
		pa = '{32'd5, 32'hffff_fffd, 32'd7, 32'h8000_0000};
		pb = '{32'd5, 32'd7, 32'hffff_fffd, 32'h7fff_ffff};
		for (int p = 0; p < 4; p++)
			for (int b = 0; b < 4; b++)
				drive(1'b1, make_branch({b[1], 1'b0, b[0]}, b[0] ? 13'h1ff8 : 13'h0040),
					pa[p], pb[p], 1'b0, 1'b0);
		drive(1'b1, make_inst(7'h5a, 5'h13, 3'd6, 5'd9, rv_pipe_pkg::OPC_LUI),
			'0, '0, 1'b0, 1'b0);
		drive(1'b1, make_inst(7'h7f, 5'h1f, 3'd7, 5'd31, rv_pipe_pkg::OPC_LUI),
			'0, '0, 1'b0, 1'b0);
		drive(1'b1, make_inst(7'h12, 5'h04, 3'd1, 5'd0, rv_pipe_pkg::OPC_LUI),
			'0, '0, 1'b0, 1'b0);
		drain();

		// stall pulses in a stream
		check_latency = 1'b0;
		for (int i = 0; i < 60; i++)
			drive(1'b1, random_inst(), $urandom(), $urandom(), $urandom_range(0, 9) < 3, 1'b0);
		drain();

		// middle instruction flushed, the one ahead of it completes
		drive(1'b1, random_inst(), $urandom(), $urandom(), 1'b0, 1'b0);
		drive(1'b1, random_inst(), $urandom(), $urandom(), 1'b0, 1'b1);
		drive(1'b1, random_inst(), $urandom(), $urandom(), 1'b0, 1'b0);
		drain();

		// en low holds the register and gives no output
		drive(1'b1, random_inst(), $urandom(), $urandom(), 1'b0, 1'b0);
		en = 1'b0;
		repeat (5) drive(1'b1, random_inst(), $urandom(), $urandom(), 1'b0, 1'b0);
		en = 1'b1;
		drain();

		// reset in the middle of a stream drops what is in flight
		repeat (3) drive(1'b1, random_inst(), $urandom(), $urandom(), 1'b0, 1'b0);
		reset = 1'b1;
		drive(1'b1, random_inst(), $urandom(), $urandom(), 1'b0, 1'b0);
		exp_q.delete();
		accept_q.delete();
		drive(1'b0, '0, '0, '0, 1'b0, 1'b0);
		reset = 1'b0;
		repeat (4) drive(1'b0, '0, '0, '0, 1'b0, 1'b0);

		// random mix, flush only on edges that advance the pipeline
		issued = 0;
		while (issued < 2000) begin
			v = $urandom_range(0, 9) < 8;
			st = $urandom_range(0, 99) < 15;
			fl = !st && ($urandom_range(0, 99) < 5);
			if (v && !st && !fl)
				issued++;
			drive(v, random_inst(), $urandom(), $urandom(), st, fl);
		end
		drain();

		// let the compare process see the outputs of the last edge
		@(negedge clk);
		#1;
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

/* rv_id_exe_slice.f */
logic/rv_pipe_pkg.sv
logic/rv_id_decode.sv
logic/pipereg_id_exe.sv
logic/rv_exe_stage.sv
logic/rv_id_exe_slice.sv
tb/rv_id_exe_slice_assert.sv
tb/tb_rv_id_exe_slice.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ID/EXE slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
	--top-module tb_rv_id_exe_slice \
	--Mdir "$BUILD_DIR" -o sim_tb \
	-f rv_id_exe_slice.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/sim_tb" +verilator+error+limit+10 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qx "PASS: all tests" "$LOG" && [ "$status" -eq 0 ]; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, exit status $status"
exit 1
